// ==== list.f ====
verilog/vga_pkg.sv
verilog/vga_axis.sv
verilog/vga_regs.sv
verilog/vga_timing.sv
verilog/vga_background.sv
verilog/vga_pixel_out.sv
verilog/vga_core.sv
bench/vga_core_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary -j 0 --top-module vga_core_tb -f list.f -o vga_core_sim \
    && ./obj_dir/vga_core_sim \
    || exit 1

// ==== bench/vga_core_tb.sv ====
module vga_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import vga_pkg::*;

    localparam int CYCLE_LIMIT = 4 * 1048576 + 2000;  // four frames plus setup

    logic        clk;
    logic        reset;
    logic [31:0] wb_addr;
    logic [31:0] wb_data;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic        wb_stb;
    logic        wb_cyc;
    logic [31:0] wb_rdata;
    logic        wb_ack;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;
    logic        vga_hs;
    logic        vga_vs;

    // programmed register values as the testbench wrote them
    int          hss = 8;
    int          hse = 104;
    int          has = 160;
    int          hae = 800;
    int          vss = 2;
    int          vse = 6;
    int          vas = 20;
    int          vae = 1000;
    logic        h_pol_s = 1'b0;
    logic        v_pol_s = 1'b0;
    logic [31:0] plane0_s = '0;
    logic [31:0] plane1_s = '0;
    int          size0 = 0;
    int          size1 = 0;
    logic [11:0] color_s [4];

    integer      seed;
    logic        expect_idle = 1'b1;  // outputs must sit at their idle levels
    logic        tracking = 1'b0;     // follow the syncs and check pixels

    // owned by the comparing process
    int          x = 0;
    int          y = 0;
    int          hs_len = 0;
    int          vs_len = 0;
    int          vs_edges = 0;
    logic        h_locked = 1'b0;
    logic        v_locked = 1'b0;
    logic        was_tracking = 1'b0;
    logic        hs_on;
    logic        vs_on;
    logic        hs_was_on = 1'b0;
    logic        vs_was_on = 1'b0;
    int          cycle_count = 0;

    vga_core vga_core_i (
        .clk (clk), .reset (reset),
        .wb_addr_i (wb_addr), .wb_data_i (wb_data), .wb_sel_i (wb_sel),
        .wb_we_i (wb_we), .wb_stb_i (wb_stb), .wb_cyc_i (wb_cyc),
        .wb_data_o (wb_rdata), .wb_ack_o (wb_ack),
        .vga_r_o (vga_r), .vga_g_o (vga_g), .vga_b_o (vga_b),
        .vga_hs_o (vga_hs), .vga_vs_o (vga_vs)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;  // drive point
    endtask

    // expected colour at counter position px,py
    function automatic logic [11:0] pixel_at(input int px, input int py);
        int         dx;
        int         bit0;
        int         bit1;
        logic [1:0] idx;
        if (px < has || px >= hae || py < vas || py >= vae) begin
            return 12'h000;
        end
        dx   = px - has;
        bit0 = 31 - (dx / (size0 + 1)) % 32;  // msb first
        bit1 = 31 - (dx / (size1 + 1)) % 32;
        idx  = {plane1_s[5'(bit1)], plane0_s[5'(bit0)]};
        return color_s[idx];
    endfunction

    // one wishbone access to this block that returns a cycle after the ack
    task automatic bus_cycle(input logic [7:0] offset, input logic we,
                             input logic [31:0] data);
        int waited;
        wb_addr = {BLOCK_ID, 16'h0000, offset};
        wb_data = data;
        wb_we   = we;
        wb_stb  = 1'b1;
        wb_cyc  = 1'b1;
        waited  = 0;
        do begin
            next_cycle();
            waited++;
        end while (!wb_ack);
        compare("wb_ack_o delay", waited, 1);
        if (!we) begin
            compare("wb_data_o", wb_rdata, 0);
        end
        wb_stb = 1'b0;  // dropped on the ack cycle
        wb_cyc = 1'b0;
        wb_we  = 1'b0;
        next_cycle();
        compare("wb_ack_o", 32'(wb_ack), 0);  // single cycle ack
    endtask

    task automatic probe_foreign_block();
        wb_addr = {8'h05, 16'h0000, REG_CTRL};
        wb_data = 32'h0040_0000;  // would enable if decoded
        wb_we   = 1'b1;
        wb_stb  = 1'b1;
        wb_cyc  = 1'b1;
        repeat (8) begin
            next_cycle();
            compare("wb_ack_o", 32'(wb_ack), 0);
        end
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
        wb_we  = 1'b0;
        next_cycle();
    endtask

    task automatic set_control(input logic en, input logic hp, input logic vp);
        h_pol_s = hp;
        v_pol_s = vp;
        bus_cycle(REG_CTRL, 1'b1, {9'd0, en, hp, vp, 10'(hae), 10'(vae)});
    endtask

    task automatic load_background(input int s0, input int s1);
        size0    = s0;
        size1    = s1;
        plane0_s = $random(seed);
        plane1_s = $random(seed);
        for (int i = 0; i < 4; i++) begin
            color_s[i] = 12'($random(seed));
        end
        bus_cycle(REG_BG_PLANE0, 1'b1, plane0_s);
        bus_cycle(REG_BG_PLANE1, 1'b1, plane1_s);
        bus_cycle(REG_BG_SIZE, 1'b1, {20'd0, 6'(s0), 6'(s1)});
        bus_cycle(REG_BG_COL01, 1'b1, {8'd0, color_s[1], color_s[0]});
        bus_cycle(REG_BG_COL23, 1'b1, {8'd0, color_s[3], color_s[2]});
    endtask

    // idle at the new polarity and then one full checked frame
    task automatic run_frame(input logic hp, input logic vp);
        expect_idle = 1'b0;
        set_control(1'b0, hp, vp);
        repeat (2) next_cycle();
        expect_idle = 1'b1;
        repeat (16) next_cycle();
        expect_idle = 1'b0;
        tracking    = 1'b1;
        set_control(1'b1, hp, vp);
        while (vs_edges < 2) begin
            next_cycle();
        end
    endtask

    // disable while the frame is running
    task automatic stop_mid_frame();
        tracking = 1'b0;
        set_control(1'b0, h_pol_s, v_pol_s);
        repeat (2) next_cycle();  // third cycle after the ack
        expect_idle = 1'b1;
        repeat (16) next_cycle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // comparing process sampling between rising edges
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!reset) begin
            hs_on = (vga_hs != h_pol_s);
            vs_on = (vga_vs != v_pol_s);
            if (expect_idle) begin
                compare("vga_rgb", 32'({vga_r, vga_g, vga_b}), 0);
                compare("vga_hs_o", 32'(vga_hs), 32'(h_pol_s));
                compare("vga_vs_o", 32'(vga_vs), 32'(v_pol_s));
            end
            if (tracking && !was_tracking) begin
                h_locked = 1'b0;  // position unknown at the start of a run
                v_locked = 1'b0;
                vs_edges = 0;
                x = 0;
                y = 0;
            end
            if (tracking) begin
                if (hs_on && !hs_was_on) begin
                    x        = hss;
                    h_locked = 1'b1;
                    hs_len   = 1;
                end else begin
                    x = x + 1;
                    if (x == 1024) begin
                        x = 0;
                        y = (y + 1) % 1024;
                    end
                    if (hs_on) begin
                        hs_len++;
                    end
                end
                if (!hs_on && hs_was_on && h_locked) begin
                    compare("vga_hs_o active cycles", hs_len, hse - hss);
                end
                if (vs_on && !vs_was_on) begin
                    if (h_locked) begin
                        compare("x at vga_vs_o edge", x, 0);
                    end
                    y        = vss;
                    v_locked = h_locked;
                    vs_len   = 1;
                    vs_edges++;
                end else if (vs_on) begin
                    vs_len++;
                end
                if (!vs_on && vs_was_on && v_locked) begin
                    compare("vga_vs_o active cycles", vs_len, (vse - vss) * 1024);
                end
                if (h_locked && v_locked) begin
                    compare("vga_rgb", 32'({vga_r, vga_g, vga_b}), 32'(pixel_at(x, y)));
                end
            end
            was_tracking = tracking;
            hs_was_on    = hs_on;
            vs_was_on    = vs_on;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset   = 1'b1;
        wb_addr = '0;
        wb_data = '0;
        wb_sel  = 4'hf;  // byte lanes ignored by the core
        wb_we   = 1'b0;
        wb_stb  = 1'b0;
        wb_cyc  = 1'b0;
        seed    = 32'hfa49;
        for (int i = 0; i < 4; i++) begin
            color_s[i] = '0;
        end
        repeat (5) next_cycle();
        reset = 1'b0;
        repeat (20) next_cycle();  // disabled after reset

        // bus handshake
        probe_foreign_block();
        bus_cycle(REG_CTRL, 1'b0, 32'h0);
        bus_cycle(REG_HTIME, 1'b1, {2'b00, 10'(hss), 10'(hse), 10'(has)});
        bus_cycle(REG_VTIME, 1'b1, {2'b00, 10'(vss), 10'(vse), 10'(vas)});

        load_background(0, 3);
        bus_cycle(8'h18, 1'b1, 32'hffff_ffff);  // unmapped offset
        repeat (10) next_cycle();
        run_frame(1'b0, 1'b0);
        stop_mid_frame();

        load_background(7, 0);
        run_frame(1'b1, 1'b1);  // inverted syncs
        stop_mid_frame();

        load_background(3, 7);
        run_frame(1'b0, 1'b1);
        stop_mid_frame();

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== verilog/vga_core.sv ====
module vga_core (
    input  logic              clk,
    input  logic              reset,

    // wishbone slave
    input  vga_pkg::wb_word_t wb_addr_i,
    input  vga_pkg::wb_word_t wb_data_i,
    input  logic [3:0]        wb_sel_i,   // byte lanes not decoded
    input  logic              wb_we_i,
    input  logic              wb_stb_i,
    input  logic              wb_cyc_i,
    output vga_pkg::wb_word_t wb_data_o,
    output logic              wb_ack_o,

    // video
    output logic [3:0]        vga_r_o,
    output logic [3:0]        vga_g_o,
    output logic [3:0]        vga_b_o,
    output logic              vga_hs_o,
    output logic              vga_vs_o
);
    import vga_pkg::*;

    coord_t     h_sync_start, h_sync_end, h_active_start, h_active_end;
    coord_t     v_sync_start, v_sync_end, v_active_start, v_active_end;
    logic       h_pol, v_pol, enabled;
    pattern_t   bg_plane0, bg_plane1;
    pix_size_t  bg_size0, bg_size1;
    color_t     bg_color0, bg_color1, bg_color2, bg_color3;
    logic       h_sync, v_sync, h_active, v_active, active;
    color_idx_t bg_index;

    vga_regs vga_regs_i (
        .clk (clk), .reset (reset),
        .wb_addr_i (wb_addr_i), .wb_data_i (wb_data_i), .wb_we_i (wb_we_i),
        .wb_stb_i (wb_stb_i), .wb_cyc_i (wb_cyc_i),
        .wb_data_o (wb_data_o), .wb_ack_o (wb_ack_o),
        .h_sync_start_o (h_sync_start), .h_sync_end_o (h_sync_end),
        .h_active_start_o (h_active_start), .h_active_end_o (h_active_end),
        .v_sync_start_o (v_sync_start), .v_sync_end_o (v_sync_end),
        .v_active_start_o (v_active_start), .v_active_end_o (v_active_end),
        .h_pol_o (h_pol), .v_pol_o (v_pol), .enabled_o (enabled),
        .bg_plane0_o (bg_plane0), .bg_plane1_o (bg_plane1),
        .bg_size0_o (bg_size0), .bg_size1_o (bg_size1),
        .bg_color0_o (bg_color0), .bg_color1_o (bg_color1),
        .bg_color2_o (bg_color2), .bg_color3_o (bg_color3)
    );

    vga_timing vga_timing_i (
        .clk (clk), .reset (reset), .enabled_i (enabled),
        .h_sync_start_i (h_sync_start), .h_sync_end_i (h_sync_end),
        .h_active_start_i (h_active_start), .h_active_end_i (h_active_end),
        .v_sync_start_i (v_sync_start), .v_sync_end_i (v_sync_end),
        .v_active_start_i (v_active_start), .v_active_end_i (v_active_end),
        .h_pol_i (h_pol), .v_pol_i (v_pol),
        .h_sync_o (h_sync), .v_sync_o (v_sync),
        .h_active_o (h_active), .v_active_o (v_active), .active_o (active)
    );

    vga_background vga_background_i (
        .clk (clk), .reset (reset),
        .h_active_i (h_active), .v_active_i (v_active),
        .bg_plane0_i (bg_plane0), .bg_plane1_i (bg_plane1),
        .bg_size0_i (bg_size0), .bg_size1_i (bg_size1),
        .bg_index_o (bg_index)
    );

    vga_pixel_out vga_pixel_out_i (
        .clk (clk), .reset (reset),
        .active_i (active), .h_sync_i (h_sync), .v_sync_i (v_sync),
        .bg_index_i (bg_index),
        .bg_color0_i (bg_color0), .bg_color1_i (bg_color1),
        .bg_color2_i (bg_color2), .bg_color3_i (bg_color3),
        .vga_r_o (vga_r_o), .vga_g_o (vga_g_o), .vga_b_o (vga_b_o),
        .vga_hs_o (vga_hs_o), .vga_vs_o (vga_vs_o)
    );

endmodule

// ==== verilog/vga_pixel_out.sv ====
module vga_pixel_out (
    input  logic                clk,
    input  logic                reset,

    input  logic                active_i,
    input  logic                h_sync_i,
    input  logic                v_sync_i,

    input  vga_pkg::color_idx_t bg_index_i,
    input  vga_pkg::color_t     bg_color0_i,
    input  vga_pkg::color_t     bg_color1_i,
    input  vga_pkg::color_t     bg_color2_i,
    input  vga_pkg::color_t     bg_color3_i,

    output logic [3:0]          vga_r_o,
    output logic [3:0]          vga_g_o,
    output logic [3:0]          vga_b_o,
    output logic                vga_hs_o,
    output logic                vga_vs_o
);
    import vga_pkg::*;

    color_t color;

    always_comb begin
        case (bg_index_i)
            2'd0:    color = bg_color0_i;
            2'd1:    color = bg_color1_i;
            2'd2:    color = bg_color2_i;
            default: color = bg_color3_i;
        endcase
    end

    // rgb and syncs leave on the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            {vga_r_o, vga_g_o, vga_b_o} <= '0;
            vga_hs_o <= 1'b0;
            vga_vs_o <= 1'b0;
        end else begin
            {vga_r_o, vga_g_o, vga_b_o} <= active_i ? color : '0;  // black in blanking
            vga_hs_o <= h_sync_i;
            vga_vs_o <= v_sync_i;
        end
    end

endmodule

// ==== verilog/vga_background.sv ====
module vga_background (
    input  logic                clk,
    input  logic                reset,

    input  logic                h_active_i,
    input  logic                v_active_i,

    input  vga_pkg::pattern_t   bg_plane0_i,
    input  vga_pkg::pattern_t   bg_plane1_i,
    input  vga_pkg::pix_size_t  bg_size0_i,
    input  vga_pkg::pix_size_t  bg_size1_i,

    output vga_pkg::color_idx_t bg_index_o
);
    import vga_pkg::*;

    pattern_t   plane   [2];
    pix_size_t  size    [2];
    pix_size_t  width_q [2];   // pixels spent on the current bit
    logic [4:0] pos_q   [2];   // bit position, 0 is the msb

    assign plane[0] = bg_plane0_i;
    assign plane[1] = bg_plane1_i;
    assign size[0]  = bg_size0_i;
    assign size[1]  = bg_size1_i;

    //////////////////////////////////////////////////////////////////////
    // plane walkers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (reset || !h_active_i) begin
                width_q[i] <= '0;  // restart on every line
                pos_q[i]   <= '0;
            end else if (v_active_i) begin
                if (width_q[i] == size[i]) begin
                    width_q[i] <= '0;
                    pos_q[i]   <= pos_q[i] + 1'b1;  // wraps after 32 bits
                end else begin
                    width_q[i] <= width_q[i] + 1'b1;
                end
            end
        end
    end

    // ~pos picks bit 31 - pos, msb first
    assign bg_index_o = {plane[1][~pos_q[1]], plane[0][~pos_q[0]]};

endmodule

// ==== verilog/vga_timing.sv ====
module vga_timing (
    input  logic            clk,
    input  logic            reset,
    input  logic            enabled_i,

    input  vga_pkg::coord_t h_sync_start_i,
    input  vga_pkg::coord_t h_sync_end_i,
    input  vga_pkg::coord_t h_active_start_i,
    input  vga_pkg::coord_t h_active_end_i,
    input  vga_pkg::coord_t v_sync_start_i,
    input  vga_pkg::coord_t v_sync_end_i,
    input  vga_pkg::coord_t v_active_start_i,
    input  vga_pkg::coord_t v_active_end_i,
    input  logic            h_pol_i,
    input  logic            v_pol_i,

    output logic            h_sync_o,
    output logic            v_sync_o,
    output logic            h_active_o,
    output logic            v_active_o,
    output logic            active_o
);

    logic h_wrap;

    vga_axis h_axis_i (
        .clk            (clk),
        .reset          (reset),
        .enabled_i      (enabled_i),
        .step_i         (1'b1),               // one pixel per clock
        .sync_start_i   (h_sync_start_i),
        .sync_end_i     (h_sync_end_i),
        .active_start_i (h_active_start_i),
        .active_end_i   (h_active_end_i),
        .pol_i          (h_pol_i),
        .count_o        (),
        .wrap_o         (h_wrap),
        .sync_o         (h_sync_o),
        .active_o       (h_active_o)
    );

    vga_axis v_axis_i (
        .clk            (clk),
        .reset          (reset),
        .enabled_i      (enabled_i),
        .step_i         (h_wrap),             // one line per horizontal wrap
        .sync_start_i   (v_sync_start_i),
        .sync_end_i     (v_sync_end_i),
        .active_start_i (v_active_start_i),
        .active_end_i   (v_active_end_i),
        .pol_i          (v_pol_i),
        .count_o        (),
        .wrap_o         (),
        .sync_o         (v_sync_o),
        .active_o       (v_active_o)
    );

    assign active_o = h_active_o && v_active_o;

endmodule

// ==== verilog/vga_regs.sv ====
module vga_regs (
    input  logic              clk,
    input  logic              reset,

    // wishbone slave
    input  vga_pkg::wb_word_t wb_addr_i,
    input  vga_pkg::wb_word_t wb_data_i,
    input  logic              wb_we_i,
    input  logic              wb_stb_i,
    input  logic              wb_cyc_i,
    output vga_pkg::wb_word_t wb_data_o,
    output logic              wb_ack_o,

    // timing fields
    output vga_pkg::coord_t   h_sync_start_o,
    output vga_pkg::coord_t   h_sync_end_o,
    output vga_pkg::coord_t   h_active_start_o,
    output vga_pkg::coord_t   h_active_end_o,
    output vga_pkg::coord_t   v_sync_start_o,
    output vga_pkg::coord_t   v_sync_end_o,
    output vga_pkg::coord_t   v_active_start_o,
    output vga_pkg::coord_t   v_active_end_o,
    output logic              h_pol_o,
    output logic              v_pol_o,
    output logic              enabled_o,

    // background fields
    output vga_pkg::pattern_t  bg_plane0_o,
    output vga_pkg::pattern_t  bg_plane1_o,
    output vga_pkg::pix_size_t bg_size0_o,
    output vga_pkg::pix_size_t bg_size1_o,
    output vga_pkg::color_t    bg_color0_o,
    output vga_pkg::color_t    bg_color1_o,
    output vga_pkg::color_t    bg_color2_o,
    output vga_pkg::color_t    bg_color3_o
);
    import vga_pkg::*;

    logic access;

    // one access per ack, a held stb is not seen twice
    assign access = wb_stb_i && wb_cyc_i && (wb_addr_i[31:24] == BLOCK_ID) && !wb_ack_o;

    assign wb_data_o = '0;  // registers are write-only

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack_o         <= 1'b0;
            h_sync_start_o   <= '0;
            h_sync_end_o     <= '0;
            h_active_start_o <= '0;
            h_active_end_o   <= '0;
            v_sync_start_o   <= '0;
            v_sync_end_o     <= '0;
            v_active_start_o <= '0;
            v_active_end_o   <= '0;
            h_pol_o          <= 1'b0;
            v_pol_o          <= 1'b0;
            enabled_o        <= 1'b0;
            bg_plane0_o      <= '0;
            bg_plane1_o      <= '0;
            bg_size0_o       <= '0;
            bg_size1_o       <= '0;
            bg_color0_o      <= '0;
            bg_color1_o      <= '0;
            bg_color2_o      <= '0;
            bg_color3_o      <= '0;
        end else begin
            wb_ack_o <= access;  // reads and writes alike
            if (access && wb_we_i) begin
                case (wb_addr_i[7:0])
                    REG_HTIME: {h_sync_start_o, h_sync_end_o, h_active_start_o} <=
                        wb_data_i[29:0];
                    REG_VTIME: {v_sync_start_o, v_sync_end_o, v_active_start_o} <=
                        wb_data_i[29:0];
                    REG_CTRL: {enabled_o, h_pol_o, v_pol_o, h_active_end_o, v_active_end_o} <=
                        wb_data_i[22:0];
                    REG_BG_PLANE0: bg_plane0_o <= wb_data_i;
                    REG_BG_PLANE1: bg_plane1_o <= wb_data_i;
                    REG_BG_SIZE:   {bg_size0_o, bg_size1_o} <= wb_data_i[11:0];
                    REG_BG_COL01:  {bg_color1_o, bg_color0_o} <= wb_data_i[23:0];
                    REG_BG_COL23:  {bg_color3_o, bg_color2_o} <= wb_data_i[23:0];
                    default: ;  // unmapped, acked only
                endcase
            end
        end
    end

endmodule

// ==== verilog/vga_axis.sv ====
module vga_axis (
    input  logic            clk,
    input  logic            reset,
    input  logic            enabled_i,
    input  logic            step_i,        // advance by one

    input  vga_pkg::coord_t sync_start_i,
    input  vga_pkg::coord_t sync_end_i,
    input  vga_pkg::coord_t active_start_i,
    input  vga_pkg::coord_t active_end_i,
    input  logic            pol_i,

    output vga_pkg::coord_t count_o,
    output logic            wrap_o,        // last step of this axis
    output logic            sync_o,
    output logic            active_o
);

    logic in_sync;
    logic in_active;

    // windows are half open, start included and end excluded
    assign in_sync   = (count_o >= sync_start_i) && (count_o < sync_end_i);
    assign in_active = (count_o >= active_start_i) && (count_o < active_end_i);

    assign wrap_o = enabled_i && step_i && (count_o == '1);

    always_ff @(posedge clk) begin
        if (reset) begin
            count_o  <= '0;
            sync_o   <= 1'b0;
            active_o <= 1'b0;
        end else if (!enabled_i) begin
            count_o  <= '0;
            sync_o   <= pol_i;       // idle level
            active_o <= 1'b0;
        end else begin
            if (step_i) begin
                count_o <= count_o + 1'b1;  // wraps at 1023
            end
            // one cycle behind the counter
            sync_o   <= in_sync ^ pol_i;
            active_o <= in_active;
        end
    end

endmodule

// ==== verilog/vga_pkg.sv ====
package vga_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    typedef logic [9:0]  coord_t;      // counter value or timing setting
    typedef logic [11:0] color_t;      // {red, green, blue} nibbles
    typedef logic [31:0] pattern_t;    // one background bit-plane
    typedef logic [5:0]  pix_size_t;   // plane pixel width, minus one
    typedef logic [1:0]  color_idx_t;  // background colour index
    typedef logic [31:0] wb_word_t;    // wishbone address or data

    //////////////////////////////////////////////////////////////////////
    // bus decode
    //////////////////////////////////////////////////////////////////////

    localparam logic [7:0] BLOCK_ID = 8'h04;  // address bits 31..24

    // write-only register offsets, all cleared by reset
    //   00  [29:20] h_sync_start  [19:10] h_sync_end  [9:0] h_active_start
    //   04  [29:20] v_sync_start  [19:10] v_sync_end  [9:0] v_active_start
    //   08  [22] enable  [21] h_pol  [20] v_pol
    //       [19:10] h_active_end  [9:0] v_active_end
    //   0C  plane 0 bits
    //   10  plane 1 bits
    //   14  [11:6] plane 0 width  [5:0] plane 1 width
    //   1C  [23:12] colour 1  [11:0] colour 0
    //   20  [23:12] colour 3  [11:0] colour 2
    localparam logic [7:0] REG_HTIME     = 8'h00;
    localparam logic [7:0] REG_VTIME     = 8'h04;
    localparam logic [7:0] REG_CTRL      = 8'h08;
    localparam logic [7:0] REG_BG_PLANE0 = 8'h0C;
    localparam logic [7:0] REG_BG_PLANE1 = 8'h10;
    localparam logic [7:0] REG_BG_SIZE   = 8'h14;
    localparam logic [7:0] REG_BG_COL01  = 8'h1C;
    localparam logic [7:0] REG_BG_COL23  = 8'h20;

endpackage
